//--- verilog/tlb_pkg.sv
// tlb package
// widths, sizes, PTE flag positions and encodings shared by the Sv32 TLB

package tlb_pkg;

    // array geometry
    localparam int TLB_SETS = 16;
    localparam int TLB_WAYS = 2;
    localparam int SET_BITS = 4;
    localparam int WAY_BITS = 1;

    // Sv32 address fields
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS         = 20;
    localparam int TAG_BITS         = VPN_BITS - SET_BITS;   // vpn bits above the index
    localparam int ASID_BITS        = 9;
    localparam int PPN_BITS         = 22;
    localparam int PADDR_BITS       = PPN_BITS + PAGE_OFFSET_BITS;
    localparam int PTE_BITS         = 32;

    // flag bits of a leaf pte
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    localparam int PTE_PPN_LSB = 10;   // ppn sits in 31:10

    typedef logic [VPN_BITS-1:0]   vpn_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [SET_BITS-1:0]   set_idx_t;
    typedef logic [WAY_BITS-1:0]   way_idx_t;
    typedef logic [ASID_BITS-1:0]  asid_t;
    typedef logic [PPN_BITS-1:0]   ppn_t;
    typedef logic [PADDR_BITS-1:0] paddr_t;
    typedef logic [PTE_BITS-1:0]   pte_t;

    // kind of access being translated
    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_INSN  = 2'd2
    } access_e;

    typedef enum logic [1:0] {
        ST_FLUSH  = 2'd0,   // clear every entry after reset
        ST_LOOKUP = 2'd1,
        ST_REFILL = 2'd2,   // waiting on the page walker
        ST_FENCE  = 2'd3
    } tlb_state_e;

endpackage

//--- verilog/tlb_sweep_counter.sv
// tlb sweep counter
// steps through every way of every set for the flush and fence sweeps

`timescale 1ns/1ps

module tlb_sweep_counter (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                clear,
    input  logic                advance,
    output tlb_pkg::set_idx_t   sweep_set,
    output tlb_pkg::way_idx_t   sweep_way,
    output logic                sweep_last
);

    localparam int CNT_BITS = tlb_pkg::SET_BITS + tlb_pkg::WAY_BITS;

    // way in the low bits so both ways of a set come back to back
    logic [CNT_BITS-1:0] count;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (advance) begin
            count <= count + 1'b1;   // wraps to zero after the last pair
        end
    end

    assign sweep_set  = count[CNT_BITS-1:tlb_pkg::WAY_BITS];
    assign sweep_way  = count[tlb_pkg::WAY_BITS-1:0];
    assign sweep_last = &count;

endmodule

//--- verilog/tlb_array.sv
// tlb entry storage
// two-way array of tag, asid, pte and valid with asynchronous read of one set,
// plus one last-used way bit per set

`timescale 1ns/1ps

module tlb_array (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  tlb_pkg::set_idx_t                            idx,
    input  logic                                         we,
    input  tlb_pkg::way_idx_t                            wr_way,
    input  logic                                         wr_valid,
    input  tlb_pkg::tag_t                                wr_tag,
    input  tlb_pkg::asid_t                               wr_asid,
    input  tlb_pkg::pte_t                                wr_pte,
    input  logic                                         touch,
    input  tlb_pkg::way_idx_t                            touch_way,
    output logic [tlb_pkg::TLB_WAYS-1:0]                 rd_valid,
    output tlb_pkg::tag_t  [tlb_pkg::TLB_WAYS-1:0]       rd_tag,
    output tlb_pkg::asid_t [tlb_pkg::TLB_WAYS-1:0]       rd_asid,
    output tlb_pkg::pte_t  [tlb_pkg::TLB_WAYS-1:0]       rd_pte,
    output tlb_pkg::way_idx_t                            last_used
);

    logic [tlb_pkg::TLB_WAYS-1:0]           valid_q [tlb_pkg::TLB_SETS];
    tlb_pkg::tag_t  [tlb_pkg::TLB_WAYS-1:0] tag_q   [tlb_pkg::TLB_SETS];
    tlb_pkg::asid_t [tlb_pkg::TLB_WAYS-1:0] asid_q  [tlb_pkg::TLB_SETS];
    tlb_pkg::pte_t  [tlb_pkg::TLB_WAYS-1:0] pte_q   [tlb_pkg::TLB_SETS];
    tlb_pkg::way_idx_t                      lru_q   [tlb_pkg::TLB_SETS];

    // control bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < tlb_pkg::TLB_SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            if (we) begin
                valid_q[idx][wr_way] <= wr_valid;   // only the selected way
            end
            if (touch) begin
                lru_q[idx] <= touch_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            tag_q[idx][wr_way]  <= wr_tag;
            asid_q[idx][wr_way] <= wr_asid;
            pte_q[idx][wr_way]  <= wr_pte;
        end
    end

    assign rd_valid  = valid_q[idx];
    assign rd_tag    = tag_q[idx];
    assign rd_asid   = asid_q[idx];
    assign rd_pte    = pte_q[idx];
    assign last_used = lru_q[idx];

endmodule

//--- verilog/tlb_match.sv
// tlb match logic
// compares both ways of the addressed set, picks the hit and victim ways,
// checks page permissions and decides which entries a fence removes

`timescale 1ns/1ps

module tlb_match (
    input  tlb_pkg::tlb_state_e                    state,
    input  logic [31:0]                            req_vaddr,
    input  tlb_pkg::access_e                       req_access,
    input  logic                                   req_user,
    input  tlb_pkg::asid_t                         satp_asid,
    input  logic [tlb_pkg::TLB_WAYS-1:0]           rd_valid,
    input  tlb_pkg::tag_t  [tlb_pkg::TLB_WAYS-1:0] rd_tag,
    input  tlb_pkg::asid_t [tlb_pkg::TLB_WAYS-1:0] rd_asid,
    input  tlb_pkg::pte_t  [tlb_pkg::TLB_WAYS-1:0] rd_pte,
    input  tlb_pkg::way_idx_t                      last_used,
    input  tlb_pkg::set_idx_t                      sweep_set,
    input  tlb_pkg::way_idx_t                      sweep_way,
    input  tlb_pkg::vpn_t                          fence_vpn,
    input  tlb_pkg::asid_t                         fence_asid,
    input  logic                                   walk_fault_seen,
    output logic                                   hit,
    output logic                                   fault,
    output tlb_pkg::way_idx_t                      hit_way,
    output tlb_pkg::way_idx_t                      victim_way,
    output logic                                   fence_hit,
    output tlb_pkg::paddr_t                        resp_paddr,
    output logic                                   fault_load,
    output logic                                   fault_store,
    output logic                                   fault_insn
);

    tlb_pkg::tag_t req_tag;
    tlb_pkg::pte_t hit_pte;
    tlb_pkg::pte_t sw_pte;
    logic          hit_any;
    logic          perm_fault;
    logic          vpn_ok;
    logic          asid_ok;

    assign req_tag = req_vaddr[31 -: tlb_pkg::TAG_BITS];

    // first valid way with matching tag and asid
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < tlb_pkg::TLB_WAYS; w++) begin
            if (!hit_any && rd_valid[w] && rd_tag[w] == req_tag && rd_asid[w] == satp_asid) begin
                hit_any = 1'b1;
                hit_way = tlb_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit        = hit_any && (state == tlb_pkg::ST_LOOKUP);   // no hits while sweeping
    assign hit_pte    = rd_pte[hit_way];
    assign victim_way = ~last_used;
    assign resp_paddr = {hit_pte[tlb_pkg::PTE_PPN_LSB +: tlb_pkg::PPN_BITS],
                         req_vaddr[tlb_pkg::PAGE_OFFSET_BITS-1:0]};

    always_comb begin
        perm_fault = !hit_pte[tlb_pkg::PTE_V]
                   || (hit_pte[tlb_pkg::PTE_W] && !hit_pte[tlb_pkg::PTE_R])  // reserved
                   || !hit_pte[tlb_pkg::PTE_A];                              // no A update
        case (req_access)
            tlb_pkg::ACC_LOAD:  perm_fault = perm_fault || !hit_pte[tlb_pkg::PTE_R];
            tlb_pkg::ACC_STORE: perm_fault = perm_fault || !hit_pte[tlb_pkg::PTE_W]
                                           || !hit_pte[tlb_pkg::PTE_D];
            tlb_pkg::ACC_INSN:  perm_fault = perm_fault || !hit_pte[tlb_pkg::PTE_X];
            default:            perm_fault = perm_fault;
        endcase
        // user pages only for user mode, supervisor never touches them
        perm_fault = perm_fault || (req_user != hit_pte[tlb_pkg::PTE_U]);
    end

    assign fault       = (hit && perm_fault) || walk_fault_seen;
    assign fault_load  = fault && (req_access == tlb_pkg::ACC_LOAD);
    assign fault_store = fault && (req_access == tlb_pkg::ACC_STORE);
    assign fault_insn  = fault && (req_access == tlb_pkg::ACC_INSN);

    // fence selection on the swept entry, zero fields match everything
    assign sw_pte    = rd_pte[sweep_way];
    assign vpn_ok    = (fence_vpn == '0) || ({rd_tag[sweep_way], sweep_set} == fence_vpn);
    assign asid_ok   = (fence_asid == '0)
                     || (rd_asid[sweep_way] == fence_asid && !sw_pte[tlb_pkg::PTE_G]);
    assign fence_hit = (state == tlb_pkg::ST_FENCE) && rd_valid[sweep_way] && vpn_ok && asid_ok;

endmodule

//--- verilog/tlb_ctrl.sv
// tlb control FSM
// sequences the reset flush, lookups, refills from the page walker and the
// fence sweep, and drives the array write controls

`timescale 1ns/1ps

module tlb_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  req_valid,
    input  logic                  hit,
    input  logic                  fault,
    input  logic                  fence,
    input  logic                  walk_done,
    input  logic                  walk_fault,
    input  logic                  sweep_last,
    input  logic                  fence_hit,
    input  tlb_pkg::way_idx_t     sweep_way,
    input  tlb_pkg::way_idx_t     victim_way,
    output tlb_pkg::tlb_state_e   state,
    output logic                  req_busy,
    output logic                  walk_req,
    output logic                  arr_we,
    output logic                  arr_fill,        // 1 writes a new entry, 0 clears one
    output logic                  arr_idx_sweep,
    output tlb_pkg::way_idx_t     arr_way,
    output logic                  cnt_clear,
    output logic                  cnt_advance,
    output logic                  fence_done,
    output logic                  walk_fault_seen
);

    tlb_pkg::tlb_state_e next_state;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state           <= tlb_pkg::ST_FLUSH;
            walk_fault_seen <= 1'b0;
        end else begin
            state           <= next_state;
            // held for one cycle so the lookup state can answer with the fault
            walk_fault_seen <= (state == tlb_pkg::ST_REFILL) && walk_fault && !walk_done;
        end
    end

    always_comb begin
        next_state    = state;
        req_busy      = 1'b1;
        walk_req      = 1'b0;
        arr_we        = 1'b0;
        arr_fill      = 1'b0;
        arr_idx_sweep = 1'b0;
        arr_way       = victim_way;
        cnt_clear     = 1'b0;
        cnt_advance   = 1'b0;
        fence_done    = 1'b0;

        case (state)
            tlb_pkg::ST_FLUSH: begin
                arr_idx_sweep = 1'b1;
                arr_way       = sweep_way;
                arr_we        = 1'b1;            // clear every swept entry
                cnt_advance   = 1'b1;
                if (sweep_last) begin
                    next_state = tlb_pkg::ST_LOOKUP;
                end
            end
            tlb_pkg::ST_LOOKUP: begin
                // fault covers both a permission fault and a failed walk
                if (req_valid && (hit || fault)) begin
                    req_busy = 1'b0;
                end
                if (fence) begin
                    cnt_clear  = 1'b1;
                    next_state = tlb_pkg::ST_FENCE;
                end else if (req_valid && !hit && !fault) begin
                    next_state = tlb_pkg::ST_REFILL;
                end
            end
            tlb_pkg::ST_REFILL: begin
                walk_req = 1'b1;
                if (walk_done) begin
                    arr_we     = 1'b1;
                    arr_fill   = 1'b1;           // written into the victim way
                    next_state = tlb_pkg::ST_LOOKUP;
                end else if (walk_fault) begin
                    next_state = tlb_pkg::ST_LOOKUP;   // nothing written
                end
            end
            tlb_pkg::ST_FENCE: begin
                arr_idx_sweep = 1'b1;
                arr_way       = sweep_way;
                arr_we        = fence_hit;       // only selected entries go
                cnt_advance   = 1'b1;
                if (sweep_last) begin
                    fence_done = 1'b1;
                    next_state = tlb_pkg::ST_LOOKUP;
                end
            end
            default: begin
                next_state = tlb_pkg::ST_FLUSH;
            end
        endcase
    end

endmodule

//--- verilog/tlb.sv
// Sv32 TLB top
// two-way set-associative translation cache with page walker refill and fence
// sweep; the request and the fence fields are held steady while busy

`timescale 1ns/1ps

module tlb (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req_valid,
    input  logic [31:0]         req_vaddr,
    input  tlb_pkg::access_e    req_access,
    input  logic                req_user,
    input  tlb_pkg::asid_t      satp_asid,
    output logic                req_busy,
    output tlb_pkg::paddr_t     resp_paddr,
    output logic                fault_load,
    output logic                fault_store,
    output logic                fault_insn,
    output logic                walk_req,
    output tlb_pkg::vpn_t       walk_vpn,
    input  logic                walk_done,
    input  tlb_pkg::pte_t       walk_pte,
    input  logic                walk_fault,
    input  logic                fence,        // one-cycle pulse
    input  tlb_pkg::vpn_t       fence_vpn,    // held until fence_done
    input  tlb_pkg::asid_t      fence_asid,
    output logic                fence_done
);

    tlb_pkg::tlb_state_e                    state;
    logic                                   hit, fault, fence_hit, walk_fault_seen;
    logic                                   arr_we, arr_fill, arr_idx_sweep;
    logic                                   cnt_clear, cnt_advance, sweep_last;
    tlb_pkg::way_idx_t                      arr_way, hit_way, victim_way, sweep_way, last_used;
    tlb_pkg::set_idx_t                      sweep_set, arr_idx;
    logic [tlb_pkg::TLB_WAYS-1:0]           rd_valid;
    tlb_pkg::tag_t  [tlb_pkg::TLB_WAYS-1:0] rd_tag;
    tlb_pkg::asid_t [tlb_pkg::TLB_WAYS-1:0] rd_asid;
    tlb_pkg::pte_t  [tlb_pkg::TLB_WAYS-1:0] rd_pte;

    // sweeps address by counter, everything else by the request vpn
    assign arr_idx  = arr_idx_sweep ? sweep_set
                                    : req_vaddr[tlb_pkg::PAGE_OFFSET_BITS +: tlb_pkg::SET_BITS];
    assign walk_vpn = req_vaddr[31:tlb_pkg::PAGE_OFFSET_BITS];

    tlb_ctrl u_ctrl (
        .CLK, .nRST, .req_valid, .hit, .fault, .fence, .walk_done, .walk_fault,
        .sweep_last, .fence_hit, .sweep_way, .victim_way, .state, .req_busy, .walk_req,
        .arr_we, .arr_fill, .arr_idx_sweep, .arr_way, .cnt_clear, .cnt_advance,
        .fence_done, .walk_fault_seen
    );

    tlb_sweep_counter u_sweep (
        .CLK, .nRST, .clear(cnt_clear), .advance(cnt_advance),
        .sweep_set, .sweep_way, .sweep_last
    );

    // every lookup hit marks its way as last used
    tlb_array u_array (
        .CLK, .nRST, .idx(arr_idx), .we(arr_we), .wr_way(arr_way), .wr_valid(arr_fill),
        .wr_tag(req_vaddr[31 -: tlb_pkg::TAG_BITS]), .wr_asid(satp_asid), .wr_pte(walk_pte),
        .touch(hit), .touch_way(hit_way),
        .rd_valid, .rd_tag, .rd_asid, .rd_pte, .last_used
    );

    tlb_match u_match (
        .state, .req_vaddr, .req_access, .req_user, .satp_asid,
        .rd_valid, .rd_tag, .rd_asid, .rd_pte, .last_used,
        .sweep_set, .sweep_way, .fence_vpn, .fence_asid, .walk_fault_seen,
        .hit, .fault, .hit_way, .victim_way, .fence_hit,
        .resp_paddr, .fault_load, .fault_store, .fault_insn
    );

endmodule

//--- tb/tlb_assert.sv
// TLB protocol checks
// walker handshake, fault encoding, fence length and the reset flush

`timescale 1ns/1ps

module tlb_assert (
    input logic                  CLK,
    input logic                  nRST,
    input tlb_pkg::tlb_state_e   state,
    input logic                  req_valid,
    input logic                  req_busy,
    input logic                  walk_req,
    input logic                  walk_done,
    input logic                  walk_fault,
    input logic                  fault_load,
    input logic                  fault_store,
    input logic                  fault_insn,
    input logic                  fence,
    input logic                  fence_done
);

    localparam int SWEEP = tlb_pkg::TLB_SETS * tlb_pkg::TLB_WAYS;

    int flush_cnt;   // saturating count of cycles since reset

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            flush_cnt <= 0;
        end else if (flush_cnt != SWEEP) begin
            flush_cnt <= flush_cnt + 1;
        end
    end

    a_walk_hold: assert property (@(posedge CLK) disable iff (!nRST)
        walk_req && !walk_done && !walk_fault |=> walk_req)
        else $error("walk_req dropped before the walker answered");

    // a fault on a pending request is always the answer
    a_fault_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        (fault_load || fault_store || fault_insn)
        |-> $onehot0({fault_load, fault_store, fault_insn}) && !(req_valid && req_busy))
        else $error("fault on more than one output or while the request is held busy");

    // fence_done on the last sweep cycle
    a_fence_len: assert property (@(posedge CLK) disable iff (!nRST)
        fence && state == tlb_pkg::ST_LOOKUP |-> ##SWEEP $rose(fence_done))
        else $error("fence_done not on the last sweep cycle");

    a_flush_busy: assert property (@(posedge CLK) disable iff (!nRST)
        flush_cnt < SWEEP |-> req_busy && !walk_req && !fence_done)
        else $error("TLB not busy during the reset flush");

endmodule

bind tlb tlb_assert u_assert (
    .CLK(CLK), .nRST(nRST), .state(state), .req_valid(req_valid), .req_busy(req_busy),
    .walk_req(walk_req), .walk_done(walk_done), .walk_fault(walk_fault),
    .fault_load(fault_load), .fault_store(fault_store), .fault_insn(fault_insn),
    .fence(fence), .fence_done(fence_done)
);

//--- tb/tb_tlb.sv
// testbench for the Sv32 TLB
// models the page walker and a reference TLB, runs directed accesses and
// fences, and compares every response

`timescale 1ns/1ps

module tb_tlb;

    localparam int CLK_PERIOD = 4;
    localparam int DRIVE_DLY  = 1;
    localparam int SWEEP      = tlb_pkg::TLB_SETS * tlb_pkg::TLB_WAYS;
    localparam int NUM_REQS   = 48;
    localparam int NUM_FENCES = 5;
    localparam int REQ_CYCLES = 10;   // idle, miss, up to 5 refill cycles, answer
    localparam int TIMEOUT_NS = CLK_PERIOD *
                                (NUM_REQS * REQ_CYCLES + (NUM_FENCES + 1) * (SWEEP + 4) + 16);
    localparam tlb_pkg::asid_t ASID_A = 9'h011;
    localparam tlb_pkg::asid_t ASID_B = 9'h022;

    logic                CLK;
    logic                nRST;
    logic                req_valid;
    logic [31:0]         req_vaddr;
    tlb_pkg::access_e    req_access;
    logic                req_user;
    tlb_pkg::asid_t      satp_asid;
    logic                req_busy;
    tlb_pkg::paddr_t     resp_paddr;
    logic                fault_load, fault_store, fault_insn;
    logic                walk_req;
    tlb_pkg::vpn_t       walk_vpn;
    logic                walk_done;
    tlb_pkg::pte_t       walk_pte;
    logic                walk_fault;
    logic                fence;
    tlb_pkg::vpn_t       fence_vpn;
    tlb_pkg::asid_t      fence_asid;
    logic                fence_done;

    // reference TLB contents
    logic                m_valid [tlb_pkg::TLB_SETS][tlb_pkg::TLB_WAYS];
    tlb_pkg::tag_t       m_tag   [tlb_pkg::TLB_SETS][tlb_pkg::TLB_WAYS];
    tlb_pkg::asid_t      m_asid  [tlb_pkg::TLB_SETS][tlb_pkg::TLB_WAYS];
    tlb_pkg::pte_t       m_pte   [tlb_pkg::TLB_SETS][tlb_pkg::TLB_WAYS];
    logic                m_lru   [tlb_pkg::TLB_SETS];

    logic [2:0]          exp_fault_q [$];   // {insn, store, load}
    tlb_pkg::paddr_t     exp_pa_q    [$];
    int                  exp_walk_q  [$];
    logic [31:0]         lcg_state = 32'h145e7b08;
    int                  walks_seen = 0;
    int                  req_count = 0;
    int                  resp_count = 0;
    int                  last_latency;
    int                  w_delay;
    tlb_pkg::pte_t       w_pte;
    logic [2:0]          c_fault;
    tlb_pkg::paddr_t     c_pa;
    int                  c_walks;

    tlb DUT (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // walker page table where the upper vpn nibble picks the page kind
    function automatic tlb_pkg::pte_t page_entry(tlb_pkg::vpn_t vpn, tlb_pkg::asid_t asid);
        logic [7:0]    flags;
        tlb_pkg::ppn_t ppn;
        ppn = {2'b10, vpn ^ 20'h3c3c3} ^ {asid, 13'h0};   // asid gives its own frame
        case (vpn[19:16])
            4'h1:    flags = 8'hcf;   // supervisor rwx
            4'h2:    flags = 8'h53;   // user read only
            4'h3:    flags = 8'h59;   // user execute only
            4'h4:    flags = 8'h57;   // user rw with D clear
            4'h5:    flags = 8'h9f;   // user rwx with A clear
            4'h6:    flags = 8'hef;   // global supervisor rwx
            4'h7:    flags = 8'h00;   // unmapped
            4'h8:    flags = 8'hd5;   // W without R
            default: flags = 8'hdf;   // user rwx
        endcase
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic access_ok(tlb_pkg::pte_t pte, tlb_pkg::access_e acc, logic user);
        logic ok;
        ok = pte[tlb_pkg::PTE_V] && pte[tlb_pkg::PTE_A]
             && !(pte[tlb_pkg::PTE_W] && !pte[tlb_pkg::PTE_R]);
        if (acc == tlb_pkg::ACC_LOAD && !pte[tlb_pkg::PTE_R])
            ok = 1'b0;
        if (acc == tlb_pkg::ACC_STORE && !(pte[tlb_pkg::PTE_W] && pte[tlb_pkg::PTE_D]))
            ok = 1'b0;
        if (acc == tlb_pkg::ACC_INSN && !pte[tlb_pkg::PTE_X])
            ok = 1'b0;
        if (user && !pte[tlb_pkg::PTE_U])
            ok = 1'b0;
        if (!user && pte[tlb_pkg::PTE_U])
            ok = 1'b0;
        return ok;
    endfunction

    // predicts faults, address and walk count of one access and updates the model
    function automatic logic [2:0] predict_access(input logic [31:0] va,
            input tlb_pkg::access_e acc, input logic user, input tlb_pkg::asid_t asid,
            output tlb_pkg::paddr_t pa, output int walks);
        tlb_pkg::set_idx_t s;
        tlb_pkg::pte_t     pte;
        logic [2:0]        acc_bit;
        int                way;
        s       = va[15:12];
        acc_bit = 3'b001 << acc;
        way     = -1;
        walks   = 0;
        pa      = '0;
        for (int w = 0; w < tlb_pkg::TLB_WAYS; w++) begin
            if (way < 0 && m_valid[s][w] && m_tag[s][w] == va[31:16] && m_asid[s][w] == asid)
                way = w;
        end
        if (way < 0) begin
            walks = 1;
            pte   = page_entry(va[31:12], asid);
            if (!pte[tlb_pkg::PTE_V])
                return acc_bit;   // walk fault leaves the set unfilled
            way             = !m_lru[s];
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = va[31:16];
            m_asid[s][way]  = asid;
            m_pte[s][way]   = pte;
        end
        m_lru[s] = way[0];
        pte      = m_pte[s][way];
        pa       = {pte[31:10], va[11:0]};
        return access_ok(pte, acc, user) ? 3'b000 : acc_bit;
    endfunction

    function automatic void apply_fence(tlb_pkg::vpn_t vpn, tlb_pkg::asid_t asid);
        for (int s = 0; s < tlb_pkg::TLB_SETS; s++) begin
            for (int w = 0; w < tlb_pkg::TLB_WAYS; w++) begin
                if ((vpn == '0 || {m_tag[s][w], tlb_pkg::set_idx_t'(s)} == vpn)
                    && (asid == '0 || (m_asid[s][w] == asid && !m_pte[s][w][tlb_pkg::PTE_G])))
                    m_valid[s][w] = 1'b0;
            end
        end
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic access(input logic [31:0] va, input tlb_pkg::access_e acc, input logic user,
                          input tlb_pkg::asid_t asid);
        logic [2:0]      f;
        tlb_pkg::paddr_t pa;
        int              walks;
        f = predict_access(va, acc, user, asid, pa, walks);
        exp_fault_q.push_back(f);
        exp_pa_q.push_back(pa);
        exp_walk_q.push_back(walks);
        req_count++;
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid  = 1'b1;
        req_vaddr  = va;
        req_access = acc;
        req_user   = user;
        satp_asid  = asid;
        last_latency = 0;
        @(negedge CLK);
        while (req_busy) begin
            last_latency++;
            @(negedge CLK);
        end
        if (walks == 0)
            check("hit_latency", last_latency, 0);   // hits answer in the same cycle
        @(posedge CLK);
        #DRIVE_DLY;
        req_valid = 1'b0;   // address stays put so idle lookups touch nothing new
    endtask

    task automatic fence_sweep(input tlb_pkg::vpn_t vpn, input tlb_pkg::asid_t asid);
        int len;
        apply_fence(vpn, asid);
        @(posedge CLK);
        #DRIVE_DLY;
        fence      = 1'b1;
        fence_vpn  = vpn;
        fence_asid = asid;
        @(posedge CLK);
        #DRIVE_DLY;
        fence = 1'b0;
        len   = 1;
        @(negedge CLK);
        while (!fence_done) begin
            len++;
            @(negedge CLK);
        end
        check("fence_cycles", len, SWEEP);
    endtask

    // walker model with a delay of 1 to 4 cycles
    always begin
        @(negedge CLK);
        if (walk_req) begin
            check("walk_vpn", walk_vpn, req_vaddr[31:12]);
            w_delay = 1 + int'(lcg_next() >> 16) % 4;
            w_pte   = page_entry(walk_vpn, satp_asid);
            repeat (w_delay) @(posedge CLK);
            #DRIVE_DLY;
            walk_pte   = w_pte;
            walk_done  = w_pte[tlb_pkg::PTE_V];
            walk_fault = !w_pte[tlb_pkg::PTE_V];
            walks_seen++;
            @(posedge CLK);
            #DRIVE_DLY;
            walk_done  = 1'b0;
            walk_fault = 1'b0;
        end
    end

    // response compare
    always @(negedge CLK) begin
        if (nRST && req_valid && !req_busy) begin
            if (exp_fault_q.size() == 0) begin
                $display("ERROR: response seen with no request outstanding");
                $display("Verification failed");
                $fatal(1);
            end else begin
                c_fault = exp_fault_q.pop_front();
                c_pa    = exp_pa_q.pop_front();
                c_walks = exp_walk_q.pop_front();
                check("fault_load", fault_load, c_fault[0]);
                check("fault_store", fault_store, c_fault[1]);
                check("fault_insn", fault_insn, c_fault[2]);
                if (c_fault == 3'b000)
                    check("resp_paddr", resp_paddr, c_pa);
                check("walk_count", walks_seen, c_walks);
                walks_seen = 0;
                resp_count++;
            end
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("ERROR: timeout, the DUT stopped answering");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        req_valid = 1'b0;
        req_vaddr = '0;
        req_access = tlb_pkg::ACC_LOAD;
        req_user = 1'b0;
        satp_asid = '0;
        walk_done = 1'b0;
        walk_pte = '0;
        walk_fault = 1'b0;
        fence = 1'b0;
        fence_vpn = '0;
        fence_asid = '0;
        for (int s = 0; s < tlb_pkg::TLB_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < tlb_pkg::TLB_WAYS; w++)
                m_valid[s][w] = 1'b0;
        end
        repeat (4) @(posedge CLK);
        #DRIVE_DLY;
        nRST = 1'b1;

        access(32'h0001_3abc, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);   // waits out the flush
        check("flush_wait", last_latency >= SWEEP, 1);
        access(32'h0001_3123, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0001_3ffc, tlb_pkg::ACC_STORE, 1'b1, ASID_A);
        // set 3 replacement
        access(32'h0002_3010, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0001_3000, tlb_pkg::ACC_INSN, 1'b1, ASID_A);
        access(32'h0003_3020, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0002_3010, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0003_3444, tlb_pkg::ACC_STORE, 1'b1, ASID_A);
        access(32'h0001_3000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        // permissions
        access(32'h1001_5800, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h1001_5800, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        access(32'h1001_5804, tlb_pkg::ACC_INSN, 1'b0, ASID_A);
        access(32'h0003_3444, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        access(32'h2001_6100, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h2001_6100, tlb_pkg::ACC_STORE, 1'b1, ASID_A);
        access(32'h2001_6100, tlb_pkg::ACC_INSN, 1'b1, ASID_A);
        access(32'h3001_7200, tlb_pkg::ACC_INSN, 1'b1, ASID_A);
        access(32'h3001_7200, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h4001_8300, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h4001_8300, tlb_pkg::ACC_STORE, 1'b1, ASID_A);
        access(32'h5001_9400, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h5001_9400, tlb_pkg::ACC_INSN, 1'b1, ASID_A);
        access(32'h8001_a500, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h7001_b600, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h7001_b600, tlb_pkg::ACC_STORE, 1'b1, ASID_A);
        // fences
        access(32'h0004_1000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        access(32'h6004_5000, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        access(32'h0004_6000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        fence_sweep(20'h00042, '0);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        access(32'h0004_1000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        fence_sweep('0, ASID_A);
        access(32'h0004_1000, tlb_pkg::ACC_LOAD, 1'b1, ASID_A);
        access(32'h6004_5000, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        access(32'h0004_6000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        fence_sweep(20'h00046, ASID_B);
        access(32'h0004_6000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        fence_sweep(20'h60045, ASID_A);   // global page stays
        access(32'h6004_5000, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        fence_sweep('0, '0);
        access(32'h6004_5000, tlb_pkg::ACC_LOAD, 1'b0, ASID_A);
        access(32'h0004_2000, tlb_pkg::ACC_LOAD, 1'b1, ASID_B);
        // same vpn under two asids
        for (int i = 0; i < 4; i++)
            access(32'h0004_7abc, tlb_pkg::ACC_LOAD, 1'b1, i[0] ? ASID_B : ASID_A);

        @(posedge CLK);
        if (resp_count != req_count || exp_fault_q.size() != 0) begin
            $display("ERROR: %0d requests issued, %0d answered", req_count, resp_count);
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
verilog/tlb_pkg.sv
verilog/tlb_sweep_counter.sv
verilog/tlb_array.sv
verilog/tlb_match.sv
verilog/tlb_ctrl.sv
verilog/tlb.sv
tb/tlb_assert.sv
tb/tb_tlb.sv

//--- Bender.yml
package:
  name: tlb

sources:
  - verilog/tlb_pkg.sv
  - verilog/tlb_sweep_counter.sv
  - verilog/tlb_array.sv
  - verilog/tlb_match.sv
  - verilog/tlb_ctrl.sv
  - verilog/tlb.sv
  - target: test
    files:
      - tb/tlb_assert.sv
      - tb/tb_tlb.sv
